/* rtl/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

    typedef logic [15:0] instrT;
    typedef logic [15:0] addrT;
    typedef logic [2:0]  condT;  // instr[15:13]

    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
    } flagsT;

    // opcodes live in instr[7:3] with instr[2:0] zero
    localparam logic [4:0] opAluRegFirst = 5'd1;
    localparam logic [4:0] opAluRegLast  = 5'd12;
    localparam logic [4:0] opJmp         = 5'd22;
    localparam logic [4:0] opCall        = 5'd23;
    localparam logic [4:0] opRet         = 5'd24;
    localparam logic [4:0] opHlt         = 5'd29;

    localparam logic [3:0] aluPassB = 4'd0;
    localparam logic [3:0] spLowReg = 4'd14;  // low byte of the stack pointer pair

    typedef enum logic [3:0] {
        clsAluImm, clsAluReg, clsIn, clsOut, clsJmp, clsCall, clsRet, clsHlt, clsNop
    } instrClassT;

    typedef struct packed {
        instrClassT cls;
        logic [3:0] aluMode;
        logic [3:0] outBSel;
        logic       condMet;
        logic       setsFlags;
    } decodedT;

    typedef enum logic [2:0] {
        stExec, stInRead, stJmpLoad, stCallPush, stRetPop, stRetLoad, stIrqPush
    } ctrlStateT;

    typedef enum logic [1:0] {srcAluOut = 2'd0, srcIoData = 2'd2} regSrcT;
    typedef enum logic [0:0] {aSelStatus = 1'b0, aSelRegA = 1'b1} aluASelT;
    typedef enum logic [1:0] {bSelRegB = 2'd0, bSelImm8 = 2'd2} aluBSelT;

    typedef enum logic [2:0] {
        memDataPcHigh = 3'd0,   // msb of pc + 1
        memDataPcLow = 3'd1,
        memDataAluOut = 3'd2,
        memDataRetHigh = 3'd3,  // interrupted address
        memDataRetLow = 3'd4
    } memDataSelT;

    typedef enum logic [1:0] {
        memAddrPointer = 2'd0, memAddrPort = 2'd1, memAddrPointerPlusOne = 2'd2
    } memAddrSelT;

    typedef enum logic [2:0] {
        fetchPcPlusOne = 3'd0,
        fetchPcOut = 3'd1,
        fetchVector = 3'd2,
        fetchIMemOut = 3'd3,
        fetchReturnAddr = 3'd5  // return reg and popped byte
    } fetchSelT;

    typedef enum logic [1:0] {statusAluFlags = 2'd0, statusDisableInt = 2'd3} statusSrcT;

    typedef struct packed {
        regSrcT     src;
        logic [3:0] outBSel;
        logic       writeEn;
        logic       incPair;
        logic       decPair;
    } regCtrlT;

    typedef struct packed {
        aluASelT    srcASel;
        aluBSelT    srcBSel;
        logic [3:0] mode;
    } aluCtrlT;

    typedef struct packed {
        memDataSelT dataSel;
        memAddrSelT addrSel;
        logic       writeEn;
        logic       readEn;
    } memCtrlT;

    typedef struct packed {
        fetchSelT addrSel;
        logic     readEn;
        logic     pcWriteEn;
    } fetchCtrlT;

    typedef struct packed {
        statusSrcT srcSel;
        logic      flagEnable;
    } statusCtrlT;

endpackage

`default_nettype wire

/* rtl/irqLatch.sv */
`timescale 1ns/1ns
`default_nettype none

module irqLatch
    import ctrlPkg::*;
#(
    parameter addrT irqVector0 = 16'h000F,
    parameter addrT irqVector1 = 16'h0020,
    parameter addrT irqVector2 = 16'h0030
) (
    input  logic       clk,
    input  logic       arstN,
    input  logic [2:0] irq,
    input  logic       irqAck,
    output logic       irqPending,
    output addrT       interruptVector
);

    logic [2:0] irqFlags;
    logic [2:0] ackMask;  // one-hot of the source being served

    // bit 0 has the highest priority
    always_comb begin
        ackMask = 3'b000;
        interruptVector = '0;
        if (irqFlags[0]) begin
            ackMask = 3'b001;
            interruptVector = irqVector0;
        end else if (irqFlags[1]) begin
            ackMask = 3'b010;
            interruptVector = irqVector1;
        end else if (irqFlags[2]) begin
            ackMask = 3'b100;
            interruptVector = irqVector2;
        end
    end

    assign irqPending = |irqFlags;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            irqFlags <= 3'b000;
        end else begin
            irqFlags <= (irqFlags & ~(irqAck ? ackMask : 3'b000)) | irq;  // new request wins
        end
    end

endmodule

`default_nettype wire

/* rtl/instrDecode.sv */
`timescale 1ns/1ns
`default_nettype none

module instrDecode
    import ctrlPkg::*;
(
    input  instrT   instr,
    input  flagsT   flags,
    output decodedT dec
);

    logic [4:0] opcode;
    logic [2:0] riMode;
    condT       cond;
    logic       zeroLow;
    logic       isRegImm;
    logic       condMet;
    instrClassT cls;

    assign opcode = instr[7:3];
    assign riMode = instr[3:1];
    assign cond = instr[15:13];
    assign zeroLow = (instr[2:0] == 3'd0);
    assign isRegImm = instr[0] && (riMode < 3'd7);

    // priority follows the encoding overlaps
    always_comb begin
        if (isRegImm) begin
            cls = clsAluImm;
        end else if (instr[2:0] == 3'd2) begin
            cls = clsIn;
        end else if (instr[2:0] == 3'd4) begin
            cls = clsOut;
        end else if (zeroLow && opcode >= opAluRegFirst && opcode <= opAluRegLast) begin
            cls = clsAluReg;
        end else if (zeroLow && opcode == opJmp) begin
            cls = clsJmp;
        end else if (zeroLow && opcode == opCall) begin
            cls = clsCall;
        end else if (zeroLow && opcode == opRet) begin
            cls = clsRet;
        end else if (zeroLow && opcode == opHlt) begin
            cls = clsHlt;
        end else begin
            cls = clsNop;  // also the dropped pair and status ops
        end
    end

    always_comb begin
        case (cond)
            3'd1: condMet = flags.carry;
            3'd2: condMet = ~flags.carry;
            3'd3: condMet = flags.zero;
            3'd4: condMet = ~flags.zero;
            3'd5: condMet = flags.negative;
            3'd6: condMet = ~flags.negative;
            default: condMet = 1'b1;  // 0 and 7
        endcase
    end

    always_comb begin
        dec.cls = cls;
        dec.condMet = condMet;
        dec.aluMode = aluPassB;
        dec.outBSel = instr[15:12];
        dec.setsFlags = 1'b0;
        case (cls)
            clsAluImm: begin
                dec.aluMode = {1'b0, riMode};
                dec.setsFlags = (riMode != 3'd0);  // load-immediate keeps flags
            end
            clsAluReg: begin
                dec.aluMode = instr[6:3];
                dec.outBSel = instr[11:8];
                dec.setsFlags = 1'b1;
            end
            clsCall, clsRet: dec.outBSel = spLowReg;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/ctrlSequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module ctrlSequencer
    import ctrlPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  decodedT    dec,
    input  logic       interruptEnable,
    input  logic       irqPending,
    output regCtrlT    regCtrl,
    output aluCtrlT    aluCtrl,
    output memCtrlT    memCtrl,
    output fetchCtrlT  fetchCtrl,
    output statusCtrlT statusCtrl,
    output logic       irqAck
);

    ctrlStateT state;
    ctrlStateT nextState;
    logic      started;  // low until the first edge after reset

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stExec;
            started <= 1'b0;
        end else begin
            state <= nextState;
            started <= 1'b1;
        end
    end

    always_comb begin
        regCtrl = '{src: srcAluOut, outBSel: dec.outBSel, writeEn: 1'b0,
                    incPair: 1'b0, decPair: 1'b0};
        aluCtrl = '{srcASel: aSelRegA, srcBSel: bSelRegB, mode: aluPassB};
        memCtrl = '{dataSel: memDataAluOut, addrSel: memAddrPointer,
                    writeEn: 1'b0, readEn: 1'b0};
        fetchCtrl = '{addrSel: fetchPcOut, readEn: 1'b1, pcWriteEn: 1'b1};
        statusCtrl = '{srcSel: statusAluFlags, flagEnable: 1'b0};
        irqAck = 1'b0;
        nextState = stExec;

        case (state)
            stExec: begin
                if (interruptEnable && irqPending) begin
                    regCtrl.outBSel = spLowReg;
                    regCtrl.decPair = 1'b1;
                    memCtrl.dataSel = memDataRetLow;  // push low byte first
                    memCtrl.writeEn = 1'b1;
                    statusCtrl = '{srcSel: statusDisableInt, flagEnable: 1'b1};
                    fetchCtrl.readEn = 1'b0;
                    fetchCtrl.pcWriteEn = 1'b0;
                    nextState = stIrqPush;
                end else begin
                    case (dec.cls)
                        clsAluImm: begin
                            regCtrl.writeEn = 1'b1;
                            aluCtrl.srcBSel = bSelImm8;
                            aluCtrl.mode = dec.aluMode;
                            statusCtrl.flagEnable = dec.setsFlags;
                        end
                        clsAluReg: begin
                            regCtrl.writeEn = 1'b1;
                            aluCtrl.mode = dec.aluMode;
                            statusCtrl.flagEnable = 1'b1;
                        end
                        clsIn: begin
                            memCtrl.addrSel = memAddrPort;
                            memCtrl.readEn = 1'b1;
                            fetchCtrl.readEn = 1'b0;
                            fetchCtrl.pcWriteEn = 1'b0;
                            nextState = stInRead;
                        end
                        clsOut: begin
                            memCtrl.addrSel = memAddrPort;
                            memCtrl.writeEn = 1'b1;
                        end
                        clsJmp: begin
                            if (dec.condMet) begin
                                nextState = stJmpLoad;  // target word is fetched now
                            end else begin
                                fetchCtrl.addrSel = fetchPcPlusOne;  // skip target word
                            end
                        end
                        clsCall: begin
                            if (dec.condMet) begin
                                regCtrl.decPair = 1'b1;
                                memCtrl.dataSel = memDataPcLow;
                                memCtrl.writeEn = 1'b1;
                                fetchCtrl.pcWriteEn = 1'b0;
                                nextState = stCallPush;
                            end else begin
                                fetchCtrl.addrSel = fetchPcPlusOne;
                            end
                        end
                        clsRet: begin
                            if (dec.condMet) begin
                                regCtrl.incPair = 1'b1;
                                memCtrl.addrSel = memAddrPointerPlusOne;
                                memCtrl.readEn = 1'b1;
                                fetchCtrl = '{addrSel: fetchReturnAddr, readEn: 1'b0,
                                              pcWriteEn: 1'b0};
                                nextState = stRetPop;
                            end
                        end
                        clsHlt: begin
                            fetchCtrl.readEn = 1'b0;  // same word decoded again
                            fetchCtrl.pcWriteEn = 1'b0;
                        end
                        default: ;
                    endcase
                end
            end
            stInRead: begin
                regCtrl.src = srcIoData;
                regCtrl.writeEn = 1'b1;
                memCtrl.addrSel = memAddrPort;
                memCtrl.readEn = 1'b1;  // hold the port data
            end
            stJmpLoad: fetchCtrl.addrSel = fetchIMemOut;
            stCallPush: begin
                regCtrl.decPair = 1'b1;
                memCtrl.dataSel = memDataPcHigh;
                memCtrl.writeEn = 1'b1;
                fetchCtrl.addrSel = fetchIMemOut;
            end
            stRetPop: begin
                regCtrl.incPair = 1'b1;
                memCtrl.addrSel = memAddrPointerPlusOne;
                memCtrl.readEn = 1'b1;
                fetchCtrl = '{addrSel: fetchReturnAddr, readEn: 1'b0, pcWriteEn: 1'b0};
                nextState = stRetLoad;
            end
            stRetLoad: fetchCtrl.addrSel = fetchReturnAddr;
            stIrqPush: begin
                regCtrl.outBSel = spLowReg;
                regCtrl.decPair = 1'b1;
                memCtrl.dataSel = memDataRetHigh;
                memCtrl.writeEn = 1'b1;
                statusCtrl = '{srcSel: statusDisableInt, flagEnable: 1'b0};
                fetchCtrl.addrSel = fetchVector;
                irqAck = 1'b1;
            end
            default: ;
        endcase

        // nothing is fetched or advanced before the first edge after reset
        if (!started) begin
            fetchCtrl.readEn = 1'b0;
            fetchCtrl.pcWriteEn = 1'b0;
            nextState = stExec;
        end
    end

endmodule

`default_nettype wire

/* rtl/controlUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module controlUnit
    import ctrlPkg::*;
#(
    parameter addrT irqVector0 = 16'h000F,
    parameter addrT irqVector1 = 16'h0020,
    parameter addrT irqVector2 = 16'h0030
) (
    input  logic       clk,
    input  logic       arstN,
    input  instrT      instr,
    input  flagsT      flags,
    input  logic       interruptEnable,
    input  logic [2:0] irq,
    output regCtrlT    regCtrl,
    output aluCtrlT    aluCtrl,
    output memCtrlT    memCtrl,
    output fetchCtrlT  fetchCtrl,
    output statusCtrlT statusCtrl,
    output addrT       interruptVector
);

    decodedT dec;
    logic    irqPending;
    logic    irqAck;

    instrDecode instrDecode_inst (
        .instr(instr),
        .flags(flags),
        .dec  (dec)
    );

    irqLatch #(
        .irqVector0(irqVector0),
        .irqVector1(irqVector1),
        .irqVector2(irqVector2)
    ) irqLatch_inst (
        .clk            (clk),
        .arstN          (arstN),
        .irq            (irq),
        .irqAck         (irqAck),
        .irqPending     (irqPending),
        .interruptVector(interruptVector)
    );

    ctrlSequencer ctrlSequencer_inst (
        .clk            (clk),
        .arstN          (arstN),
        .dec            (dec),
        .interruptEnable(interruptEnable),
        .irqPending     (irqPending),
        .regCtrl        (regCtrl),
        .aluCtrl        (aluCtrl),
        .memCtrl        (memCtrl),
        .fetchCtrl      (fetchCtrl),
        .statusCtrl     (statusCtrl),
        .irqAck         (irqAck)
    );

endmodule

`default_nettype wire

/* tb/controlUnit_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module controlUnit_asserts
    import ctrlPkg::*;
(
    input logic      clk,
    input logic      arstN,
    input ctrlStateT state,
    input logic      irqAck,
    input regCtrlT   regCtrl,
    input memCtrlT   memCtrl
);

    ackOnlyInPush: assert property (@(posedge clk) disable iff (!arstN)
        irqAck |-> state == stIrqPush)  // ack closes the entry
        else $error("irqAck outside stIrqPush");

    noRegAndMemWrite: assert property (@(posedge clk) disable iff (!arstN)
        !(regCtrl.writeEn && memCtrl.writeEn))
        else $error("register write and memory write in the same cycle");

    noIncAndDec: assert property (@(posedge clk) disable iff (!arstN)
        !(regCtrl.incPair && regCtrl.decPair))  // stack moves one way at a time
        else $error("incPair and decPair both high");

endmodule

bind ctrlSequencer controlUnit_asserts seqAsserts (
    .clk    (clk),
    .arstN  (arstN),
    .state  (state),
    .irqAck (irqAck),
    .regCtrl(regCtrl),
    .memCtrl(memCtrl)
);

`default_nettype wire

/* tb/controlUnitTb.sv */
`timescale 1ns/1ns
`default_nettype none

module controlUnitTb
    import ctrlPkg::*;
();

    localparam instrT nopWord = 16'h0000;
    localparam logic [8:0] fetchOnly = 9'b000001100;  // fetch read and pcWrite

    typedef struct packed {
        instrT      word;
        logic [3:0] mode;
        aluBSelT    bSel;
        logic       regWr;
        logic       flagEn;
        logic       portWr;
        logic [3:0] outB;
        logic       fetchRun;  // fetch read and pcWrite together
    } rowT;

    logic       clk;
    logic       arstN;
    instrT      instr;
    flagsT      flags;
    logic       interruptEnable;
    logic [2:0] irq;
    regCtrlT    regCtrl;
    aluCtrlT    aluCtrl;
    memCtrlT    memCtrl;
    fetchCtrlT  fetchCtrl;
    statusCtrlT statusCtrl;
    addrT       interruptVector;
    logic [7:0] lfsr = 8'd72;

    rowT rows [10] = '{
        '{16'h5A07, 4'd3, bSelImm8, 1'b1, 1'b1, 1'b0, 4'd5, 1'b1},   // R-I mode 3
        '{16'h3C51, 4'd0, bSelImm8, 1'b1, 1'b0, 1'b0, 4'd3, 1'b1},   // load-immediate
        '{16'h710D, 4'd6, bSelImm8, 1'b1, 1'b1, 1'b0, 4'd7, 1'b1},
        '{16'h000F, 4'd0, bSelRegB, 1'b0, 1'b0, 1'b0, 4'd0, 1'b1},   // mode 7 is not R-I
        '{16'h2908, 4'd1, bSelRegB, 1'b1, 1'b1, 1'b0, 4'd9, 1'b1},   // first R-R op
        '{16'h4B60, 4'd12, bSelRegB, 1'b1, 1'b1, 1'b0, 4'd11, 1'b1}, // last R-R op
        '{16'h0068, 4'd0, bSelRegB, 1'b0, 1'b0, 1'b0, 4'd0, 1'b1},   // opcode 13
        '{16'h6014, 4'd0, bSelRegB, 1'b0, 1'b0, 1'b1, 4'd6, 1'b1},   // OUT
        '{16'h00E8, 4'd0, bSelRegB, 1'b0, 1'b0, 1'b0, 4'd0, 1'b0},   // HLT
        '{16'h80F0, 4'd0, bSelRegB, 1'b0, 1'b0, 1'b0, 4'd8, 1'b1}    // dropped opcode 30
    };

    controlUnit controlUnit_inst (
        .clk            (clk),
        .arstN          (arstN),
        .instr          (instr),
        .flags          (flags),
        .interruptEnable(interruptEnable),
        .irq            (irq),
        .regCtrl        (regCtrl),
        .aluCtrl        (aluCtrl),
        .memCtrl        (memCtrl),
        .fetchCtrl      (fetchCtrl),
        .statusCtrl     (statusCtrl),
        .interruptVector(interruptVector)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [7:0] lfsrNext(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};  // x^8 + x^6 + x^5 + x^4 + 1
    endfunction

    function automatic logic condTaken(input condT c, input flagsT f);
        case (c)
            3'd1: return f.carry;
            3'd2: return !f.carry;
            3'd3: return f.zero;
            3'd4: return !f.zero;
            3'd5: return f.negative;
            3'd6: return !f.negative;
            default: return 1'b1;  // 0 and 7
        endcase
    endfunction

    function automatic logic [8:0] enableBits();
        return {regCtrl.writeEn, regCtrl.incPair, regCtrl.decPair, memCtrl.writeEn,
                memCtrl.readEn, fetchCtrl.readEn, fetchCtrl.pcWriteEn,
                statusCtrl.flagEnable, controlUnit_inst.irqAck};
    endfunction

    task automatic drawBits(input int n, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            bits = {bits[6:0], lfsr[0]};
        end
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            abortRun($sformatf("[ERROR] %s: expected %0h, actual %0h", name, expected, actual));
        end
    endtask

    // new word on the falling edge and outputs settle before the rising one
    task automatic driveWord(input instrT w, input flagsT f);
        @(negedge clk);
        instr = w;
        flags = f;
        #2;
    endtask

    task automatic waitForVectorFetch(input int maxCycles);
        int cycles;
        cycles = 0;
        while (fetchCtrl.addrSel != fetchVector) begin
            if (cycles >= maxCycles) begin
                abortRun($sformatf("no interrupt vector fetch within %0d cycles", maxCycles));
            end else begin
                @(negedge clk);
                #2;
                cycles++;
            end
        end
    endtask

    initial begin
        logic [7:0] bits;
        condT       cond;
        flagsT      jmpFlags;
        instrT      word;
        logic       taken;

        arstN = 1'b0;
        instr = nopWord;
        flags = '0;
        interruptEnable = 1'b0;
        irq = 3'b000;

        repeat (15) @(negedge clk);
        #2;
        check("reset enables", 32'(9'b0), 32'(enableBits()));
        check("reset vector", 32'h0, 32'(interruptVector));
        @(negedge clk);
        arstN = 1'b1;
        driveWord(nopWord, '0);
        check("first exec", 32'({16'h0000, fetchOnly}), 32'({interruptVector, enableBits()}));

        foreach (rows[i]) begin
            driveWord(rows[i].word, '0);
            check($sformatf("row %0d alu", i), 32'({rows[i].mode, aSelRegA, rows[i].bSel}),
                  32'({aluCtrl.mode, aluCtrl.srcASel, aluCtrl.srcBSel}));
            check($sformatf("row %0d write", i), 32'({rows[i].regWr, rows[i].flagEn}),
                  32'({regCtrl.writeEn, statusCtrl.flagEnable}));
            check($sformatf("row %0d port", i), 32'({rows[i].portWr, rows[i].portWr}),
                  32'({memCtrl.writeEn, memCtrl.addrSel == memAddrPort}));
            check($sformatf("row %0d outB", i), 32'(rows[i].outB), 32'(regCtrl.outBSel));
            check($sformatf("row %0d fetch", i), 32'({rows[i].fetchRun, rows[i].fetchRun}),
                  32'({fetchCtrl.readEn, fetchCtrl.pcWriteEn}));
        end

        for (int k = 0; k < 16; k++) begin
            drawBits(3, bits);
            cond = bits[2:0];
            drawBits(3, bits);
            jmpFlags = bits[2:0];
            word = {cond, 5'd0, opJmp, 3'd0};
            taken = condTaken(cond, jmpFlags);
            driveWord(word, jmpFlags);
            if (taken) begin
                check($sformatf("jmp %0d taken", k), 32'({fetchPcOut, 2'b11}), 32'(fetchCtrl));
                driveWord(nopWord, '0);
                check($sformatf("jmp %0d load", k), 32'({fetchIMemOut, 2'b11}), 32'(fetchCtrl));
            end else begin
                check($sformatf("jmp %0d skip", k), 32'({fetchPcPlusOne, 2'b11}), 32'(fetchCtrl));
            end
            driveWord(nopWord, '0);
            check($sformatf("jmp %0d exec", k), 32'({fetchPcOut, 2'b11}), 32'(fetchCtrl));
        end

        driveWord(16'h60B8, '0);  // CALL on zero, zero clear
        check("call untaken", 32'({fetchPcPlusOne, 2'b11, 1'b0}),
              32'({fetchCtrl, memCtrl.writeEn}));
        driveWord(16'h00B8, '0);
        check("call push low", 32'({1'b1, memDataPcLow, 1'b1, 1'b0, spLowReg}),
              32'({memCtrl.writeEn, memCtrl.dataSel, regCtrl.decPair, fetchCtrl.pcWriteEn,
                   regCtrl.outBSel}));
        driveWord(nopWord, '0);
        check("call push high", 32'({1'b1, memDataPcHigh, 1'b1, fetchIMemOut}),
              32'({memCtrl.writeEn, memCtrl.dataSel, regCtrl.decPair, fetchCtrl.addrSel}));
        driveWord(nopWord, '0);
        check("call done", 32'(fetchOnly), 32'(enableBits()));

        for (int p = 0; p < 2; p++) begin
            driveWord((p == 0) ? 16'h00C0 : nopWord, '0);
            check($sformatf("ret pop %0d", p),
                  32'({memAddrPointerPlusOne, 1'b1, 1'b1, fetchReturnAddr, 2'b00}),
                  32'({memCtrl.addrSel, memCtrl.readEn, regCtrl.incPair, fetchCtrl}));
        end
        driveWord(nopWord, '0);
        check("ret load", 32'({fetchReturnAddr, 2'b11}), 32'(fetchCtrl));
        driveWord(nopWord, '0);
        check("ret done", 32'(fetchOnly), 32'(enableBits()));

        driveWord(16'h5002, '0);
        check("in read", 32'({memAddrPort, 1'b1, 1'b0, 1'b0, 1'b0}),
              32'({memCtrl.addrSel, memCtrl.readEn, memCtrl.writeEn, regCtrl.writeEn,
                   fetchCtrl.readEn}));
        driveWord(nopWord, '0);
        check("in write", 32'({srcIoData, 1'b1}), 32'({regCtrl.src, regCtrl.writeEn}));
        driveWord(nopWord, '0);
        check("in done", 32'(fetchOnly), 32'(enableBits()));

        @(negedge clk);
        interruptEnable = 1'b1;
        irq = 3'b110;  // two sources in the same cycle
        instr = nopWord;
        #2;
        check("irq not yet pending", 32'(fetchOnly), 32'(enableBits()));
        @(negedge clk);
        irq = 3'b000;
        #2;
        check("irq entry 1 vector", 32'h20, 32'(interruptVector));
        check("irq entry 1 push", 32'({1'b1, memDataRetLow, 1'b1, statusDisableInt, 1'b1, 1'b0}),
              32'({memCtrl.writeEn, memCtrl.dataSel, regCtrl.decPair, statusCtrl,
                   fetchCtrl.readEn}));
        waitForVectorFetch(4);
        check("irq push 1", 32'({16'h0020, memDataRetHigh, 1'b1}),
              32'({interruptVector, memCtrl.dataSel, controlUnit_inst.irqAck}));

        // source 2 still pending but masked
        @(negedge clk);
        interruptEnable = 1'b0;
        instr = 16'h2908;
        #2;
        check("masked vector", 32'h30, 32'(interruptVector));
        check("masked decode", 32'({1'b1, 1'b1, 1'b0, 4'd1, fetchPcOut, 2'b11}),
              32'({regCtrl.writeEn, statusCtrl.flagEnable, memCtrl.writeEn, aluCtrl.mode,
                   fetchCtrl}));
        @(negedge clk);
        interruptEnable = 1'b1;
        instr = nopWord;
        #2;
        check("irq entry 2 vector", 32'h30, 32'(interruptVector));
        waitForVectorFetch(4);
        check("irq push 2", 32'({16'h0030, 1'b1}),
              32'({interruptVector, controlUnit_inst.irqAck}));
        driveWord(nopWord, '0);
        check("irq none left", 32'({16'h0000, fetchOnly}), 32'({interruptVector, enableBits()}));

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
rtl/ctrlPkg.sv
rtl/irqLatch.sv
rtl/instrDecode.sv
rtl/ctrlSequencer.sv
rtl/controlUnit.sv
tb/controlUnit_asserts.sv
tb/controlUnitTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the control unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

logFile=sim.log
buildDir=obj_dir

if ! verilator --binary --timing --assert --timescale 1ns/1ns \
        -f all.f --top-module controlUnitTb -Mdir "$buildDir" -o controlUnitTbSim; then
    echo "verilator build failed"
    exit 1
fi

"./$buildDir/controlUnitTbSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "TESTBENCH FAILED" "$logFile"; then
    echo "testbench reported a failure, see $logFile"
    exit 1
fi

if [ "$simStatus" -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if ! grep -q "TESTBENCH PASSED" "$logFile"; then
    echo "simulation ended without a result line"
    exit 1
fi

exit 0
